//--- Bender.yml
package:
  name: ice_bus

sources:
  - files:
      - verilog/ice_bus_pkg.sv
      - verilog/ice_bus_if.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/ice_bus_controller.sv
      - verilog/basics_responder.sv
      - verilog/echo_responder.sv
      - verilog/ice_bus.sv
  - target: test
    files:
      - sim/ice_bus_chk.sv
      - sim/ice_bus_tb.sv

//--- project.f
verilog/ice_bus_pkg.sv
verilog/ice_bus_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/ice_bus_controller.sv
verilog/basics_responder.sv
verilog/echo_responder.sv
verilog/ice_bus.sv
sim/ice_bus_chk.sv
sim/ice_bus_tb.sv

//--- sim/ice_bus_chk.sv
module ice_bus_chk (
	input logic clk,
	input logic reset,
	input ice_bus_pkg::dev_mask_t req,
	input ice_bus_pkg::dev_mask_t grant,
	input ice_bus_pkg::dev_mask_t data_latch,
	input logic tx_char_valid,
	input logic tx_char_ready
);

	// Count of failed assertions
	int fail_cnt = 0;

	// At most one device owns the reply path
	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else begin
			$error("grant vector is not one-hot or zero");
			fail_cnt++;
		end

	// Grant only while the device still requests
	grant_req: assert property (@(posedge clk) disable iff (reset) (grant & ~req) == '0)
		else begin
			$error("grant given to a device that does not request");
			fail_cnt++;
		end

	// UART must be empty when a byte is handed over
	tx_ready: assert property (@(posedge clk) disable iff (reset)
		$rose(tx_char_valid) |-> tx_char_ready)
		else begin
			$error("byte handed to the UART while it was busy");
			fail_cnt++;
		end

	// Latch pulses only toward the granted device
	latch_grant: assert property (@(posedge clk) disable iff (reset)
		|data_latch |-> ((data_latch & ~grant) == '0))
		else begin
			$error("data latch without an active grant");
			fail_cnt++;
		end

endmodule

bind ice_bus_controller ice_bus_chk u_chk (
	.clk(clk),
	.reset(reset),
	.req(req),
	.grant(grant),
	.data_latch(data_latch),
	.tx_char_valid(tx_char_valid),
	.tx_char_ready(tx_char_ready)
);

//--- sim/ice_bus_tb.sv
module ice_bus_tb;
	import ice_bus_pkg::*;

	typedef byte_t byte_q_t [$];

	localparam int CLK_PERIOD = 8;
	localparam int BIT_CLKS = 8;
	localparam int NUM_FRAMES = 45;
	// Per-frame budget is 30 byte times
	localparam int WATCHDOG_TIME = NUM_FRAMES * 30 * 10 * BIT_CLKS * CLK_PERIOD;
	localparam int REPLY_LIMIT = 20 * 10 * BIT_CLKS;
	// Quiet time after each reply where stray bytes would land
	localparam int GAP_CLKS = 2 * 10 * BIT_CLKS;
	localparam int IDLE_CLKS = 20 * BIT_CLKS;

	logic clk;
	logic reset;
	logic uart_rx_line;
	logic uart_tx_line;

	byte_q_t exp_q;
	byte_q_t got_q;
	int err_cnt = 0;
	int byte_cnt = 0;
	int got_total = 0;
	int frame_cnt = 0;

	ice_bus #(.CLKS_PER_BIT(BIT_CLKS)) dut (
		.clk(clk),
		.reset(reset),
		.uart_rx_line(uart_rx_line),
		.uart_tx_line(uart_tx_line)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Expected reply bytes for one host frame
	function automatic byte_q_t expect_reply(input byte_t addr, input byte_t id,
		input byte_t len, input byte_q_t data);
		byte_q_t r;
		// Oversized frames are dropped silently
		if (len > 8) begin
			return r;
		end
		if (addr == ADDR_VERSION) begin
			r = '{8'h56, id, 8'd2, 8'd1, 8'd3};
		end else if (addr == ADDR_ECHO) begin
			r = '{8'h45, id, len};
			foreach (data[i]) r.push_back(data[i]);
		end else begin
			// NAK without data
			r = '{8'h4E, id, 8'd0};
		end
		return r;
	endfunction

	function automatic byte_q_t random_data(input int len);
		byte_q_t d;
		for (int i = 0; i < len; i++) begin
			d.push_back(byte_t'($urandom));
		end
		return d;
	endfunction

	// Any address outside the map
	function automatic byte_t unmapped_addr();
		byte_t a;
		a = byte_t'($urandom);
		while (a == ADDR_VERSION || a == ADDR_ECHO) begin
			a = byte_t'($urandom);
		end
		return a;
	endfunction

	// One UART character with start bit, data LSB first and stop bit
	task automatic send_byte(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx_line <= bits[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
	endtask

	task automatic run_frame(input byte_t addr, input byte_t id, input byte_t len,
		input byte_q_t data);
		byte_q_t want;
		int cycles;
		want = expect_reply(addr, id, len, data);
		foreach (want[i]) exp_q.push_back(want[i]);
		send_byte(addr);
		send_byte(id);
		send_byte(len);
		foreach (data[i]) send_byte(data[i]);
		// Wait for the comparer to consume the whole reply
		cycles = 0;
		while (exp_q.size() != 0 && cycles < REPLY_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		assert (exp_q.size() == 0) else begin
			$display("frame %0d to address %h got no complete reply, %0d bytes missing",
				frame_cnt, addr, exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
		repeat (GAP_CLKS) @(posedge clk);
		frame_cnt++;
	endtask

	// Decode the DUT serial output on falling edges
	initial begin
		byte_t b;
		@(negedge reset);
		forever begin
			@(negedge clk);
			if (uart_tx_line === 1'b0) begin
				// Middle of the start bit and then one bit time per bit
				repeat (BIT_CLKS / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge clk);
					b[i] = uart_tx_line;
				end
				repeat (BIT_CLKS) @(negedge clk);
				assert (uart_tx_line === 1'b1) else begin
					$display("reply byte at time %0t has a low stop bit", $time);
					err_cnt++;
				end
				got_q.push_back(b);
				got_total++;
			end
		end
	end

	// Comparer
	initial begin
		byte_t got;
		byte_t want;
		forever begin
			@(posedge clk);
			while (got_q.size() != 0) begin
				got = got_q.pop_front();
				assert (exp_q.size() != 0) else begin
					$display("unexpected reply byte %h at time %0t, no reply was due", got, $time);
					err_cnt++;
				end
				if (exp_q.size() != 0) begin
					want = exp_q.pop_front();
					assert (got == want) else begin
						$display("mismatch at %0t: reply byte expected %h, got %h",
							$time, want, got);
						err_cnt++;
					end
					byte_cnt++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout after %0d time units, the run did not complete", WATCHDOG_TIME);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		byte_t addr;
		byte_t id;
		byte_t len;
		int kind;
		reset = 1'b1;
		uart_rx_line = 1'b1;
		void'($urandom(32'h164b));
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Quiet serial output after reset
		repeat (IDLE_CLKS) begin
			@(negedge clk);
			assert (uart_tx_line === 1'b1) else begin
				$display("mismatch at %0t: serial output before any frame expected 1, got %b",
					$time, uart_tx_line);
				err_cnt++;
			end
		end
		@(posedge clk);
		assert (got_total == 0) else begin
			$display("reply bytes arrived before the first frame was sent");
			err_cnt++;
		end

		// Version query
		run_frame(ADDR_VERSION, byte_t'($urandom), 8'd0, random_data(0));

		// Echo with random length
		len = byte_t'($urandom_range(8, 0));
		run_frame(ADDR_ECHO, byte_t'($urandom), len, random_data(len));

		// Unmapped address
		run_frame(unmapped_addr(), byte_t'($urandom), 8'd0, random_data(0));

		// Oversized frame followed by a normal one
		run_frame(ADDR_ECHO, byte_t'($urandom), 8'd9, random_data(9));
		len = byte_t'($urandom_range(8, 1));
		run_frame(ADDR_ECHO, byte_t'($urandom), len, random_data(len));

		// Mixed random traffic
		for (int n = 0; n < 40; n++) begin
			kind = $urandom_range(3, 0);
			id = byte_t'($urandom);
			len = byte_t'($urandom_range(8, 0));
			case (kind)
				0: addr = ADDR_VERSION;
				1: addr = ADDR_ECHO;
				2: addr = unmapped_addr();
				default: begin
					addr = byte_t'($urandom);
					len = byte_t'($urandom_range(12, 9));
				end
			endcase
			run_frame(addr, id, len, random_data(len));
		end

		$display("frames %0d, reply bytes checked %0d, errors %0d, assertion failures %0d",
			frame_cnt, byte_cnt, err_cnt, dut.u_ctrl.u_chk.fail_cnt);
		if (err_cnt == 0 && dut.u_ctrl.u_chk.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/basics_responder.sv
module basics_responder (
	input logic clk,
	input logic reset,
	ice_master_if.device bus,
	ice_reply_if.device rep
);
	import ice_bus_pkg::*;

	reply_state_t state;
	logic fv_q;
	logic frame_end;
	// Unmapped address, answer with a NAK
	logic nak;
	byte_t id;
	// Second version byte
	logic minor_sel;

	assign frame_end = fv_q & ~bus.ma_frame_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RS_IDLE;
			fv_q <= 1'b0;
			nak <= 1'b0;
			minor_sel <= 1'b0;
		end else begin
			fv_q <= bus.ma_frame_valid;
			case (state)
				RS_IDLE: begin
					// Everything except the echo address is ours
					if (frame_end && bus.ma_addr != ADDR_ECHO) begin
						nak <= (bus.ma_addr != ADDR_VERSION);
						id <= bus.ma_id;
						minor_sel <= 1'b0;
						state <= RS_REQUEST;
					end
				end
				RS_REQUEST: if (rep.arb_grant) state <= RS_TYPE;
				RS_TYPE: if (rep.data_latch) state <= RS_ID;
				RS_ID: if (rep.data_latch) state <= RS_LEN;
				RS_LEN: begin
					if (rep.data_latch) begin
						state <= nak ? RS_IDLE : RS_DATA;
					end
				end
				RS_DATA: begin
					if (rep.data_latch) begin
						minor_sel <= 1'b1;
						if (minor_sel) begin
							state <= RS_IDLE;
						end
					end
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	// Request held until the last byte is taken
	assign rep.arb_request = (state != RS_IDLE);

	always_comb begin
		rep.data = nak ? REPLY_NAK : ADDR_VERSION;
		rep.last = 1'b0;
		case (state)
			RS_ID: rep.data = id;
			RS_LEN: begin
				rep.data = nak ? 8'd0 : 8'd2;
				rep.last = nak;
			end
			RS_DATA: begin
				rep.data = minor_sel ? VER_MINOR : VER_MAJOR;
				rep.last = minor_sel;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/echo_responder.sv
module echo_responder (
	input logic clk,
	input logic reset,
	ice_master_if.device bus,
	ice_reply_if.device rep
);
	import ice_bus_pkg::*;

	reply_state_t state;
	logic fv_q;
	logic frame_end;
	logic wr_en;
	len_t wr_idx;
	len_t rd_idx;
	len_t len_q;
	byte_t id;
	byte_t mem [MAX_LEN];

	assign frame_end = fv_q & ~bus.ma_frame_valid;
	assign wr_en = bus.ma_frame_valid & bus.ma_data_valid & (bus.ma_addr == ADDR_ECHO);

	// Frame data, controller never sends more than MAX_LEN
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx[2:0]] <= bus.ma_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RS_IDLE;
			fv_q <= 1'b0;
			wr_idx <= '0;
			rd_idx <= '0;
		end else begin
			fv_q <= bus.ma_frame_valid;
			// Write pointer restarts with every frame
			if (!bus.ma_frame_valid) begin
				wr_idx <= '0;
			end else if (wr_en) begin
				wr_idx <= wr_idx + 1'b1;
			end
			case (state)
				RS_IDLE: begin
					if (frame_end && bus.ma_addr == ADDR_ECHO) begin
						len_q <= bus.ma_len;
						id <= bus.ma_id;
						rd_idx <= '0;
						state <= RS_REQUEST;
					end
				end
				RS_REQUEST: if (rep.arb_grant) state <= RS_TYPE;
				RS_TYPE: if (rep.data_latch) state <= RS_ID;
				RS_ID: if (rep.data_latch) state <= RS_LEN;
				RS_LEN: begin
					if (rep.data_latch) begin
						state <= (len_q == '0) ? RS_IDLE : RS_DATA;
					end
				end
				RS_DATA: begin
					if (rep.data_latch) begin
						rd_idx <= rd_idx + 1'b1;
						if (rep.last) begin
							state <= RS_IDLE;
						end
					end
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	assign rep.arb_request = (state != RS_IDLE);

	always_comb begin
		rep.data = ADDR_ECHO;
		rep.last = 1'b0;
		case (state)
			RS_ID: rep.data = id;
			RS_LEN: begin
				rep.data = byte_t'(len_q);
				rep.last = (len_q == '0);
			end
			RS_DATA: begin
				rep.data = mem[rd_idx[2:0]];
				rep.last = (rd_idx == len_t'(len_q - 1'b1));
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/ice_bus.sv
module ice_bus #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic uart_rx_line,
	output logic uart_tx_line
);
	import ice_bus_pkg::*;

	byte_t rx_data;
	logic rx_valid;
	byte_t tx_data;
	logic tx_latch;
	logic tx_empty;

	// Frame broadcast and one reply channel per responder
	ice_master_if bus_if ();
	ice_reply_if rep_if [NUM_DEV] ();

	// Host bytes in
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.clk(clk),
		.reset(reset),
		.rx_line(uart_rx_line),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	ice_bus_controller u_ctrl (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_data),
		.rx_char_valid(rx_valid),
		.tx_char(tx_data),
		.tx_char_valid(tx_latch),
		.tx_char_ready(tx_empty),
		.bus(bus_if.master),
		.dev(rep_if)
	);

	// Device 0, version and NAK
	basics_responder u_basics (
		.clk(clk),
		.reset(reset),
		.bus(bus_if.device),
		.rep(rep_if[0].device)
	);

	// Device 1
	echo_responder u_echo (
		.clk(clk),
		.reset(reset),
		.bus(bus_if.device),
		.rep(rep_if[1].device)
	);

	// Reply bytes out
	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk(clk),
		.reset(reset),
		.tx_data(tx_data),
		.tx_latch(tx_latch),
		.tx_line(uart_tx_line),
		.tx_empty(tx_empty)
	);

endmodule

//--- verilog/ice_bus_controller.sv
module ice_bus_controller (
	input logic clk,
	input logic reset,
	input ice_bus_pkg::byte_t rx_char,
	input logic rx_char_valid,
	output ice_bus_pkg::byte_t tx_char,
	output logic tx_char_valid,
	input logic tx_char_ready,
	ice_master_if.master bus,
	ice_reply_if.arbiter dev [ice_bus_pkg::NUM_DEV]
);
	import ice_bus_pkg::*;

	parse_state_t state;
	// Data bytes still to come in this frame
	byte_t remain;
	// Oversized frame, data bytes are swallowed
	logic drop;
	// Cycles spent in reply without any request
	logic [1:0] wait_cnt;
	dev_mask_t req;
	dev_mask_t grant;
	dev_mask_t data_latch;
	dev_mask_t last_vec;
	dev_mask_t first_req;
	byte_t dev_data [NUM_DEV];
	byte_t sel_data;
	logic sel_last;
	// Byte on its way into the UART, tx_empty not yet low
	logic pending;

	// Flatten the reply interfaces
	for (genvar i = 0; i < NUM_DEV; i++) begin : g_dev
		assign req[i] = dev[i].arb_request;
		assign last_vec[i] = dev[i].last;
		assign dev_data[i] = dev[i].data;
		assign dev[i].arb_grant = grant[i];
		assign dev[i].data_latch = data_latch[i];
	end

	// Lowest set bit wins
	assign first_req = req & dev_mask_t'(~req + 1'b1);
	assign pending = (|data_latch) | tx_char_valid;

	// Byte and last flag of the granted device
	always_comb begin
		sel_data = '0;
		sel_last = 1'b0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (grant[i]) begin
				sel_data = sel_data | dev_data[i];
				sel_last = sel_last | last_vec[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= PS_ADDR;
			remain <= '0;
			drop <= 1'b0;
			wait_cnt <= '0;
			grant <= '0;
			data_latch <= '0;
			tx_char_valid <= 1'b0;
			bus.ma_frame_valid <= 1'b0;
			bus.ma_data_valid <= 1'b0;
		end else begin
			// Strobes
			bus.ma_data_valid <= 1'b0;
			data_latch <= '0;
			tx_char_valid <= 1'b0;
			case (state)
				PS_ADDR: begin
					if (rx_char_valid) begin
						bus.ma_addr <= rx_char;
						state <= PS_ID;
					end
				end
				PS_ID: begin
					if (rx_char_valid) begin
						bus.ma_id <= rx_char;
						state <= PS_LEN;
					end
				end
				PS_LEN: begin
					if (rx_char_valid) begin
						remain <= rx_char;
						state <= PS_DATA;
						if (rx_char > byte_t'(MAX_LEN)) begin
							drop <= 1'b1;
						end else begin
							// Header complete, open the frame
							drop <= 1'b0;
							bus.ma_len <= len_t'(rx_char);
							bus.ma_frame_valid <= 1'b1;
						end
					end
				end
				PS_DATA: begin
					if (remain == '0) begin
						if (drop) begin
							state <= PS_ADDR;
						end else begin
							// Frame ends here, responders act on the fall
							bus.ma_frame_valid <= 1'b0;
							wait_cnt <= '0;
							state <= PS_REPLY;
						end
					end else if (rx_char_valid) begin
						remain <= remain - 1'b1;
						if (!drop) begin
							bus.ma_data <= rx_char;
							bus.ma_data_valid <= 1'b1;
						end
					end
				end
				PS_REPLY: begin
					if (grant == '0) begin
						if (req != '0) begin
							grant <= first_req;
						end else if (wait_cnt == 2'd3) begin
							// Nobody answered
							state <= PS_ADDR;
						end else begin
							wait_cnt <= wait_cnt + 1'b1;
						end
					end else if (|data_latch) begin
						// Device byte into the UART
						tx_char <= sel_data;
						tx_char_valid <= 1'b1;
						if (sel_last) begin
							grant <= '0;
							state <= PS_ADDR;
						end
					end else if (tx_char_ready && !pending) begin
						data_latch <= grant;
					end
				end
				default: state <= PS_ADDR;
			endcase
		end
	end

endmodule

//--- verilog/ice_bus_if.sv
// Broadcast from the controller to every responder
interface ice_master_if;
	import ice_bus_pkg::*;

	addr_t ma_addr;
	byte_t ma_id;
	len_t ma_len;
	byte_t ma_data;
	// One cycle per data byte
	logic ma_data_valid;
	// High from the length byte to one cycle after the last data byte
	logic ma_frame_valid;

	modport master (
		output ma_addr, ma_id, ma_len, ma_data, ma_data_valid, ma_frame_valid
	);

	modport device (
		input ma_addr, ma_id, ma_len, ma_data, ma_data_valid, ma_frame_valid
	);
endinterface

// One per responder, request/grant plus byte handoff
interface ice_reply_if;
	import ice_bus_pkg::*;

	logic arb_request;
	logic arb_grant;
	byte_t data;
	logic last;
	// Takes data, responder advances on it
	logic data_latch;

	modport arbiter (
		input arb_request, data, last,
		output arb_grant, data_latch
	);

	modport device (
		output arb_request, data, last,
		input arb_grant, data_latch
	);
endinterface

//--- verilog/ice_bus_pkg.sv
package ice_bus_pkg;

	// One UART character or bus byte
	typedef logic [7:0] byte_t;
	// Device address on the master bus
	typedef logic [7:0] addr_t;
	// Data length of a frame
	typedef logic [3:0] len_t;

	// Responders on the reply side
	localparam int NUM_DEV = 2;
	typedef logic [NUM_DEV-1:0] dev_mask_t;

	// Longer frames are dropped by the controller
	localparam len_t MAX_LEN = 4'd8;

	// Address map
	localparam addr_t ADDR_VERSION = 8'h56;
	localparam addr_t ADDR_ECHO = 8'h45;

	// Reply type for addresses nobody owns
	localparam byte_t REPLY_NAK = 8'h4E;

	// Version data bytes
	localparam byte_t VER_MAJOR = 8'd1;
	localparam byte_t VER_MINOR = 8'd3;

	// Frame parser in the controller
	typedef enum logic [2:0] {
		PS_ADDR,
		PS_ID,
		PS_LEN,
		PS_DATA,
		PS_REPLY
	} parse_state_t;

	// Reply sequencer in every responder
	typedef enum logic [2:0] {
		RS_IDLE,
		RS_REQUEST,
		RS_TYPE,
		RS_ID,
		RS_LEN,
		RS_DATA
	} reply_state_t;

endpackage

//--- verilog/uart_rx.sv
module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic rx_line,
	output ice_bus_pkg::byte_t rx_data,
	output logic rx_valid
);
	import ice_bus_pkg::*;

	// Two-flop synchronizer, sync[1] is the usable line
	logic [1:0] sync;
	logic busy;
	logic [15:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= 2'b11;
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], rx_line};
			rx_valid <= 1'b0;
			if (!busy) begin
				// Falling start edge, wait half a bit to reach its middle
				if (!sync[1]) begin
					busy <= 1'b1;
					clk_cnt <= 16'(CLKS_PER_BIT / 2 - 1);
					bit_cnt <= '0;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				// Middle of a bit
				clk_cnt <= 16'(CLKS_PER_BIT - 1);
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0) begin
					// Start bit gone high again, just a glitch
					if (sync[1]) begin
						busy <= 1'b0;
					end
				end else if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					// Low stop bit is a framing error, no pulse
					rx_valid <= sync[1];
				end else begin
					// LSB first
					rx_data <= {sync[1], rx_data[7:1]};
				end
			end
		end
	end

endmodule

//--- verilog/uart_tx.sv
module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input ice_bus_pkg::byte_t tx_data,
	input logic tx_latch,
	output logic tx_line,
	output logic tx_empty
);
	import ice_bus_pkg::*;

	// Stop, data and start bits, bit 0 drives the line
	logic [9:0] shreg;
	logic [15:0] clk_cnt;
	logic [3:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			shreg <= '1;
			tx_empty <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				shreg <= {1'b1, tx_data, 1'b0};
				tx_empty <= 1'b0;
				clk_cnt <= 16'(CLKS_PER_BIT - 1);
				bit_cnt <= '0;
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else begin
			// End of a bit time, shift in idle ones
			clk_cnt <= 16'(CLKS_PER_BIT - 1);
			shreg <= {1'b1, shreg[9:1]};
			if (bit_cnt == 4'd9) begin
				// Stop bit done
				tx_empty <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	assign tx_line = shreg[0];

endmodule
